// File: dv/soc_bus_tb.sv
module soc_bus_tb;
	import soc_bus_pkg::*;

	localparam int TIMEOUT_CYCLES = 20;

	logic        clock = 1'b0;
	logic        reset;
	logic        ibus_request;
	addr_t       ibus_address;
	logic        ibus_ready;
	data_t       ibus_rdata;
	logic        dbus_request;
	bus_cmd_t    dbus_cmd;
	logic        dbus_ready;
	data_t       dbus_rdata;
	logic        dma_request;
	bus_cmd_t    dma_cmd;
	logic        dma_ready;
	data_t       dma_rdata;
	logic [9:0]  leds;
	fault_t      fault;
	logic [31:0] lcg_state = 32'h762c;

	soc_bus #(.RAM_WORDS(512), .LED_WIDTH(10)) dut (
		.i_clock(clock), .i_reset(reset),
		.i_ibus_request(ibus_request), .i_ibus_address(ibus_address),
		.o_ibus_ready(ibus_ready), .o_ibus_rdata(ibus_rdata),
		.i_dbus_request(dbus_request), .i_dbus_cmd(dbus_cmd),
		.o_dbus_ready(dbus_ready), .o_dbus_rdata(dbus_rdata),
		.i_dma_request(dma_request), .i_dma_cmd(dma_cmd),
		.o_dma_ready(dma_ready), .o_dma_rdata(dma_rdata),
		.o_leds(leds), .o_fault(fault)
	);

	always #20 clock = ~clock;

	// ================================================
	// Helpers
	// ================================================
	function automatic data_t next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	task automatic report_failure();
		$display("TEST FAILED");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input data_t got, input data_t expected);
		assert (got === expected) else begin
			$display("Fail %s got 0x%h expected 0x%h", name, got, expected);
			report_failure();
		end
	endtask

	function automatic logic ready_of(input requester_t port);
		case (port)
			IBUS:    return ibus_ready;
			DBUS:    return dbus_ready;
			default: return dma_ready;
		endcase
	endfunction

	// Holds reset for eight cycles
	task automatic apply_reset();
		reset = 1'b1;
		repeat (8) @(posedge clock);
		#1;
		reset = 1'b0;
	endtask

	// Counts edges until the port's ready as sampled just after each edge
	task automatic wait_ready(input requester_t port, output int cycles);
		int count;
		count = 0;
		do begin
			@(posedge clock);
			#1;
			count++;
		end while (!ready_of(port) && count < TIMEOUT_CYCLES);
		if (!ready_of(port)) begin
			$display("Timed out waiting for ready on the %s port", port.name());
			report_failure();
		end
		cycles = count;
	endtask

	// Request dropped with the command held, then one idle cycle
	task automatic do_ibus_read(input addr_t address, output data_t rdata, output int cycles);
		ibus_address = address;
		ibus_request = 1'b1;
		wait_ready(IBUS, cycles);
		rdata = ibus_rdata;
		ibus_request = 1'b0;
		@(posedge clock);
		#1;
	endtask

	task automatic do_dbus_access(input logic rw, input addr_t address, input data_t wdata,
		output data_t rdata, output int cycles);
		dbus_cmd = '{rw: rw, address: address, wdata: wdata};
		dbus_request = 1'b1;
		wait_ready(DBUS, cycles);
		rdata = dbus_rdata;
		dbus_request = 1'b0;
		@(posedge clock);
		#1;
	endtask

	task automatic do_dma_access(input logic rw, input addr_t address, input data_t wdata,
		output data_t rdata, output int cycles);
		dma_cmd = '{rw: rw, address: address, wdata: wdata};
		dma_request = 1'b1;
		wait_ready(DMA, cycles);
		rdata = dma_rdata;
		dma_request = 1'b0;
		@(posedge clock);
		#1;
	endtask

	// ================================================
	// Directed tests
	// ================================================
	task automatic reset_state();
		data_t rdata;
		int    cycles;
		check_word("o_leds", 32'(leds), 32'h0);
		check_word("o_ibus_ready", 32'(ibus_ready), 32'h0);
		check_word("o_dbus_ready", 32'(dbus_ready), 32'h0);
		check_word("o_dma_ready", 32'(dma_ready), 32'h0);
		check_word("o_fault.valid", 32'(fault.valid), 32'h0);
		do_dbus_access(1'b0, 32'h5900_0004, 32'h0, rdata, cycles);
		check_word("o_dbus_rdata", rdata, 32'h0);
	endtask

	task automatic ram_data_path();
		data_t written [8];
		data_t rdata;
		int    cycles;
		for (int i = 0; i < 8; i++) begin
			written[i] = next_random();
			do_dbus_access(1'b1, 32'h1000_0000 + 32'(i * 4), written[i], rdata, cycles);
			check_word("o_dbus_ready latency", 32'(cycles), 32'd1);
		end
		for (int i = 0; i < 8; i++) begin
			do_dbus_access(1'b0, 32'h1000_0000 + 32'(i * 4), 32'h0, rdata, cycles);
			check_word("o_dbus_rdata", rdata, written[i]);
			check_word("o_dbus_ready latency", 32'(cycles), 32'd1);
		end
	endtask

	task automatic shared_memory();
		data_t written [4];
		data_t rdata;
		int    cycles;
		for (int i = 0; i < 4; i++) begin
			written[i] = next_random();
			do_dma_access(1'b1, 32'h1000_0200 + 32'(i * 4), written[i], rdata, cycles);
		end
		for (int i = 0; i < 4; i++) begin
			do_ibus_read(32'h1000_0200 + 32'(i * 4), rdata, cycles);
			check_word("o_ibus_rdata", rdata, written[i]);
			do_dbus_access(1'b0, 32'h1000_0200 + 32'(i * 4), 32'h0, rdata, cycles);
			check_word("o_dbus_rdata", rdata, written[i]);
		end
	endtask

	task automatic port_priority();
		data_t words [3];
		data_t ibus_data;
		data_t dbus_data;
		data_t dma_data;
		int    ibus_cycles;
		int    dbus_cycles;
		int    dma_cycles;
		for (int i = 0; i < 3; i++) begin
			words[i] = next_random();
			do_dbus_access(1'b1, 32'h1000_0300 + 32'(i * 4), words[i], dbus_data, dbus_cycles);
		end
		// All three raised in the same cycle
		fork
			do_ibus_read(32'h1000_0300, ibus_data, ibus_cycles);
			do_dbus_access(1'b0, 32'h1000_0304, 32'h0, dbus_data, dbus_cycles);
			do_dma_access(1'b0, 32'h1000_0308, 32'h0, dma_data, dma_cycles);
		join
		assert (ibus_cycles < dbus_cycles && dbus_cycles < dma_cycles) else begin
			$display("Ready pulses did not follow the instruction, data, DMA order");
			report_failure();
		end
		check_word("o_ibus_rdata", ibus_data, words[0]);
		check_word("o_dbus_rdata", dbus_data, words[1]);
		check_word("o_dma_rdata", dma_data, words[2]);
	endtask

	task automatic sysreg_access();
		data_t value;
		data_t rdata;
		int    cycles;
		value = next_random();
		do_dbus_access(1'b1, 32'h5900_0000, value, rdata, cycles);
		check_word("o_dbus_ready latency", 32'(cycles), 32'd1);
		check_word("o_leds", 32'(leds), 32'(value[9:0]));
		do_dbus_access(1'b0, 32'h5900_0000, 32'h0, rdata, cycles);
		check_word("o_dbus_rdata", rdata, 32'(value[9:0]));
		value = next_random();
		do_dbus_access(1'b1, 32'h5900_0004, value, rdata, cycles);
		do_dbus_access(1'b0, 32'h5900_0004, 32'h0, rdata, cycles);
		check_word("o_dbus_rdata", rdata, value);
	endtask

	task automatic unmapped_access();
		data_t rdata;
		int    cycles;
		check_word("o_fault.valid", 32'(fault.valid), 32'h0);
		do_dma_access(1'b0, 32'h3000_1234, 32'h0, rdata, cycles);
		check_word("o_dma_ready latency", 32'(cycles), 32'd1);
		check_word("o_dma_rdata", rdata, 32'h0);
		// First fault stays put after a second one
		for (int pass = 0; pass < 2; pass++) begin
			check_word("o_fault.valid", 32'(fault.valid), 32'h1);
			check_word("o_fault.address", fault.address, 32'h3000_1234);
			check_word("o_fault.requester", 32'(fault.requester), 32'(DMA));
			if (pass == 0) begin
				do_dbus_access(1'b1, 32'h3abc_0000, next_random(), rdata, cycles);
				check_word("o_dbus_rdata", rdata, 32'h0);
			end
		end
	endtask

	initial begin
		reset = 1'b1;
		ibus_request = 1'b0;
		ibus_address = '0;
		dbus_request = 1'b0;
		dbus_cmd = '0;
		dma_request = 1'b0;
		dma_cmd = '0;
		apply_reset();
		ram_data_path();
		shared_memory();
		port_priority();
		sysreg_access();
		unmapped_access();
		// Reset again with LEDs, scratch and fault record all set
		apply_reset();
		reset_state();
		$display("TEST OK");
		$finish;
	end

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the soc_bus testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module soc_bus_tb -f soc_bus.f -o soc_bus_sim \
	&& ./obj_dir/soc_bus_sim \
	|| { echo "Simulation did not complete cleanly"; exit 1; }

// File: soc_bus.f
src/soc_bus_pkg.sv
src/bus_arbiter.sv
src/bus_decoder.sv
src/block_ram.sv
src/system_registers.sv
src/soc_bus.sv
dv/soc_bus_tb.sv

// File: src/block_ram.sv
module block_ram #(
	parameter int RAM_WORDS = soc_bus_pkg::RAM_WORDS
) (
	input  logic                  i_clock,
	input  logic                  i_request,
	input  soc_bus_pkg::bus_cmd_t i_cmd,
	output soc_bus_pkg::data_t    o_rdata,
	output logic                  o_ready
);
	import soc_bus_pkg::*;

	localparam int INDEX_WIDTH = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;

	data_t                  mem [RAM_WORDS];
	logic [INDEX_WIDTH-1:0] word_index;
	logic                   access;

	// Word address wrapping at the memory size
	assign word_index = INDEX_WIDTH'(i_cmd.address[ADDR_WIDTH-1:2] % RAM_WORDS);

	// No second answer while the request is still held
	assign access = i_request && !o_ready;

	always_ff @(posedge i_clock) begin
		o_ready <= access;
	end

	// Storage
	always_ff @(posedge i_clock) begin
		if (access && i_cmd.rw)
			mem[word_index] <= i_cmd.wdata;
	end

	// Registered read
	always_ff @(posedge i_clock) begin
		if (access)
			o_rdata <= mem[word_index];
	end

endmodule

// File: src/bus_arbiter.sv
module bus_arbiter (
	input  logic                    i_clock,
	input  logic                    i_reset,

	// Instruction port
	input  logic                    i_ibus_request,
	input  soc_bus_pkg::addr_t      i_ibus_address,
	output logic                    o_ibus_ready,
	output soc_bus_pkg::data_t      o_ibus_rdata,

	// Data port
	input  logic                    i_dbus_request,
	input  soc_bus_pkg::bus_cmd_t   i_dbus_cmd,
	output logic                    o_dbus_ready,
	output soc_bus_pkg::data_t      o_dbus_rdata,

	// DMA port
	input  logic                    i_dma_request,
	input  soc_bus_pkg::bus_cmd_t   i_dma_cmd,
	output logic                    o_dma_ready,
	output soc_bus_pkg::data_t      o_dma_rdata,

	// Shared bus
	output logic                    o_bus_request,
	output soc_bus_pkg::bus_cmd_t   o_bus_cmd,
	output soc_bus_pkg::requester_t o_owner,
	input  logic                    i_bus_ready,
	input  soc_bus_pkg::data_t      i_bus_rdata
);
	import soc_bus_pkg::*;

	requester_t grant;
	requester_t owner;
	bus_cmd_t   ibus_cmd;

	// Fetches are always reads
	assign ibus_cmd = '{rw: 1'b0, address: i_ibus_address, wdata: '0};

	// Hold the grant, else pick by fixed priority
	always_comb begin
		if (grant != NONE)
			owner = grant;
		else if (i_ibus_request)
			owner = IBUS;
		else if (i_dbus_request)
			owner = DBUS;
		else if (i_dma_request)
			owner = DMA;
		else
			owner = NONE;
	end

	// Released on the cycle after ready
	always_ff @(posedge i_clock) begin
		if (i_reset)
			grant <= NONE;
		else if (i_bus_ready)
			grant <= NONE;
		else
			grant <= owner;
	end

	// ================================================
	// Bus side mux
	// ================================================
	always_comb begin
		case (owner)
			IBUS: begin
				o_bus_request = i_ibus_request;
				o_bus_cmd = ibus_cmd;
			end
			DBUS: begin
				o_bus_request = i_dbus_request;
				o_bus_cmd = i_dbus_cmd;
			end
			DMA: begin
				o_bus_request = i_dma_request;
				o_bus_cmd = i_dma_cmd;
			end
			default: begin
				o_bus_request = 1'b0;
				o_bus_cmd = '0;
			end
		endcase
	end

	assign o_owner = owner;

	// Answer goes back to the owner alone
	assign o_ibus_ready = i_bus_ready && (owner == IBUS);
	assign o_dbus_ready = i_bus_ready && (owner == DBUS);
	assign o_dma_ready  = i_bus_ready && (owner == DMA);

	assign o_ibus_rdata = (owner == IBUS) ? i_bus_rdata : '0;
	assign o_dbus_rdata = (owner == DBUS) ? i_bus_rdata : '0;
	assign o_dma_rdata  = (owner == DMA) ? i_bus_rdata : '0;

endmodule

// File: src/bus_decoder.sv
module bus_decoder (
	input  logic                    i_clock,
	input  logic                    i_reset,

	// From the arbiter
	input  logic                    i_bus_request,
	input  soc_bus_pkg::bus_cmd_t   i_bus_cmd,
	input  soc_bus_pkg::requester_t i_owner,
	output logic                    o_bus_ready,
	output soc_bus_pkg::data_t      o_bus_rdata,

	// Target strobes and fault record
	output logic                    o_ram_request,
	output logic                    o_sysreg_request,
	output soc_bus_pkg::fault_t     o_fault,

	// Target answers
	input  logic                    i_ram_ready,
	input  soc_bus_pkg::data_t      i_ram_rdata,
	input  logic                    i_sysreg_ready,
	input  soc_bus_pkg::data_t      i_sysreg_rdata
);
	import soc_bus_pkg::*;

	logic [3:0] region;
	logic [3:0] far;
	logic       ram_select;
	logic       sysreg_select;
	logic       unmapped_access;
	logic       unmapped_ready;
	fault_t     fault;

	// ================================================
	// Region decode
	// ================================================
	assign region = i_bus_cmd.address[ADDR_WIDTH-1 -: 4];
	assign far    = i_bus_cmd.address[ADDR_WIDTH-5 -: 4];

	assign ram_select    = (region == REGION_RAM);
	assign sysreg_select = (region == REGION_BRIDGE) && (far == FAR_SYSREG);

	assign o_ram_request    = i_bus_request && ram_select;
	assign o_sysreg_request = i_bus_request && sysreg_select;

	// Anything else is unmapped including the rest of the bridge window
	assign unmapped_access = i_bus_request && !ram_select && !sysreg_select
		&& !unmapped_ready;

	// Unmapped answer and first fault capture
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			unmapped_ready <= 1'b0;
			fault <= '0;
		end else begin
			unmapped_ready <= unmapped_access;
			if (unmapped_access && !fault.valid) begin
				fault.valid <= 1'b1;
				fault.address <= i_bus_cmd.address;
				fault.requester <= i_owner;
			end
		end
	end

	// Return path
	assign o_bus_ready =
		ram_select    ? i_ram_ready    :
		sysreg_select ? i_sysreg_ready :
		unmapped_ready;

	assign o_bus_rdata =
		ram_select    ? i_ram_rdata    :
		sysreg_select ? i_sysreg_rdata :
		'0;

	assign o_fault = fault;

endmodule

// File: src/soc_bus.sv
module soc_bus #(
	parameter int RAM_WORDS = soc_bus_pkg::RAM_WORDS,
	parameter int LED_WIDTH = soc_bus_pkg::LED_WIDTH
) (
	input  logic                  i_clock,
	input  logic                  i_reset,

	input  logic                  i_ibus_request,
	input  soc_bus_pkg::addr_t    i_ibus_address,
	output logic                  o_ibus_ready,
	output soc_bus_pkg::data_t    o_ibus_rdata,

	input  logic                  i_dbus_request,
	input  soc_bus_pkg::bus_cmd_t i_dbus_cmd,
	output logic                  o_dbus_ready,
	output soc_bus_pkg::data_t    o_dbus_rdata,

	input  logic                  i_dma_request,
	input  soc_bus_pkg::bus_cmd_t i_dma_cmd,
	output logic                  o_dma_ready,
	output soc_bus_pkg::data_t    o_dma_rdata,

	output logic [LED_WIDTH-1:0]  o_leds,
	output soc_bus_pkg::fault_t   o_fault
);
	import soc_bus_pkg::*;

	// Shared bus
	logic       bus_request;
	bus_cmd_t   bus_cmd;
	requester_t owner;
	logic       bus_ready;
	data_t      bus_rdata;

	// Targets
	logic       ram_request;
	logic       ram_ready;
	data_t      ram_rdata;
	logic       sysreg_request;
	logic       sysreg_ready;
	data_t      sysreg_rdata;

	bus_arbiter arbiter (
		.i_clock(i_clock), .i_reset(i_reset),
		.i_ibus_request(i_ibus_request), .i_ibus_address(i_ibus_address),
		.o_ibus_ready(o_ibus_ready), .o_ibus_rdata(o_ibus_rdata),
		.i_dbus_request(i_dbus_request), .i_dbus_cmd(i_dbus_cmd),
		.o_dbus_ready(o_dbus_ready), .o_dbus_rdata(o_dbus_rdata),
		.i_dma_request(i_dma_request), .i_dma_cmd(i_dma_cmd),
		.o_dma_ready(o_dma_ready), .o_dma_rdata(o_dma_rdata),
		.o_bus_request(bus_request), .o_bus_cmd(bus_cmd), .o_owner(owner),
		.i_bus_ready(bus_ready), .i_bus_rdata(bus_rdata)
	);

	bus_decoder decoder (
		.i_clock(i_clock), .i_reset(i_reset),
		.i_bus_request(bus_request), .i_bus_cmd(bus_cmd), .i_owner(owner),
		.o_bus_ready(bus_ready), .o_bus_rdata(bus_rdata),
		.o_ram_request(ram_request), .o_sysreg_request(sysreg_request),
		.o_fault(o_fault),
		.i_ram_ready(ram_ready), .i_ram_rdata(ram_rdata),
		.i_sysreg_ready(sysreg_ready), .i_sysreg_rdata(sysreg_rdata)
	);

	block_ram #(.RAM_WORDS(RAM_WORDS)) ram (
		.i_clock(i_clock), .i_request(ram_request), .i_cmd(bus_cmd),
		.o_rdata(ram_rdata), .o_ready(ram_ready)
	);

	system_registers #(.LED_WIDTH(LED_WIDTH)) sysreg (
		.i_clock(i_clock), .i_reset(i_reset),
		.i_request(sysreg_request), .i_cmd(bus_cmd),
		.o_rdata(sysreg_rdata), .o_ready(sysreg_ready), .o_leds(o_leds)
	);

endmodule

// File: src/soc_bus_pkg.sv
package soc_bus_pkg;

	// Bus geometry
	localparam int ADDR_WIDTH = 32;
	localparam int DATA_WIDTH = 32;

	typedef logic [ADDR_WIDTH-1:0] addr_t;
	typedef logic [DATA_WIDTH-1:0] data_t;

	// One access as seen by the targets
	typedef struct packed {
		logic  rw;
		addr_t address;
		data_t wdata;
	} bus_cmd_t;

	// Bus owner with the same codes as the fault type
	typedef enum logic [1:0] {
		NONE = 2'd0,
		IBUS = 2'd1,
		DBUS = 2'd2,
		DMA  = 2'd3
	} requester_t;

	typedef struct packed {
		logic       valid;
		addr_t      address;
		requester_t requester;
	} fault_t;

	// Top nibble of the bus address, far nibble inside the bridge
	localparam logic [3:0] REGION_RAM    = 4'h1;
	localparam logic [3:0] REGION_BRIDGE = 4'h5;
	localparam logic [3:0] FAR_SYSREG    = 4'h9;

	// Register index from address bits 3:2
	localparam logic [1:0] SYSREG_LEDS    = 2'd0;
	localparam logic [1:0] SYSREG_SCRATCH = 2'd1;

	// Defaults for the top level
	localparam int RAM_WORDS = 512;
	localparam int LED_WIDTH = 10;

endpackage

// File: src/system_registers.sv
module system_registers #(
	parameter int LED_WIDTH = soc_bus_pkg::LED_WIDTH
) (
	input  logic                  i_clock,
	input  logic                  i_reset,
	input  logic                  i_request,
	input  soc_bus_pkg::bus_cmd_t i_cmd,
	output soc_bus_pkg::data_t    o_rdata,
	output logic                  o_ready,
	output logic [LED_WIDTH-1:0]  o_leds
);
	import soc_bus_pkg::*;

	logic [LED_WIDTH-1:0] leds;
	data_t                scratch;
	logic [1:0]           index;
	logic                 access;

	assign index  = i_cmd.address[3:2];
	assign access = i_request && !o_ready;

	// ================================================
	// Register file
	// ================================================
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			o_ready <= 1'b0;
			leds <= '0;
			scratch <= '0;
		end else begin
			o_ready <= access;
			if (access && i_cmd.rw) begin
				case (index)
					SYSREG_LEDS:    leds <= i_cmd.wdata[LED_WIDTH-1:0];
					SYSREG_SCRATCH: scratch <= i_cmd.wdata;
					default:        ;
				endcase
			end
		end
	end

	// Read back with zero for unused indices
	always_ff @(posedge i_clock) begin
		if (access) begin
			case (index)
				SYSREG_LEDS:    o_rdata <= data_t'(leds);
				SYSREG_SCRATCH: o_rdata <= scratch;
				default:        o_rdata <= '0;
			endcase
		end
	end

	assign o_leds = leds;

endmodule
